// ==== move_gen_pkg.sv ====
package move_gen_pkg;

	typedef enum logic [2:0] {
		EMPTY   = 3'd0,
		PAWN    = 3'd1,
		KNIGHT  = 3'd2,
		BISHOP  = 3'd3,
		ROOK    = 3'd4,
		QUEEN   = 3'd5,
		KING    = 3'd6,
		NOTUSED = 3'd7
	} piece_t;

	typedef struct packed {
		logic   color; // 0 white, 1 black
		piece_t piece;
	} cell_t;

	// square index is rank*8 + file, a1 at 0, h8 at 63
	typedef cell_t [63:0] board_t;

	typedef struct packed {
		logic [2:0] file; // 0 = file a
		logic [2:0] rank; // 0 = rank 1
	} square_t;

	typedef struct packed {
		logic invalid;
		logic promote;
		logic pawn_move;
		logic pawn_two;
		logic en_passant;
		logic castle;
		logic capture;
	} move_flags_t;

	// 19 bit move word: flags, from, to
	typedef struct packed {
		move_flags_t flags;
		square_t     from_sq;
		square_t     to_sq;
	} move_t;

	typedef struct packed {
		logic king_side;
		logic queen_side;
	} castle_rights_t;

	// reduced position, bit f of each vector is file f
	typedef struct packed {
		logic [7:0] white_pawn_r5;
		logic [7:0] enp;
		logic       king_side_ok;
		logic       queen_side_ok;
	} position_t;

	typedef enum logic [2:0] {IDLE, LOAD, SCAN, DRAIN, DONE} gen_state_t;

	localparam logic WHITE = 1'b0;
	localparam cell_t WHITE_PAWN = '{color: WHITE, piece: PAWN};
	localparam cell_t WHITE_ROOK = '{color: WHITE, piece: ROOK};
	localparam cell_t WHITE_KING = '{color: WHITE, piece: KING};

	localparam int SLOT_COUNT = 18; // 2 castles + 8 files x 2 sources
	localparam int SLOT_IDX_W = $clog2(SLOT_COUNT);
	localparam int QUEUE_DEPTH = 8;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CREDITS = 4;
	localparam int CREDIT_W = $clog2(QUEUE_CREDITS + 1);

	localparam move_flags_t CASTLE_FLAGS = '{castle: 1'b1, default: 1'b0};
	localparam move_flags_t ENP_FLAGS = '{pawn_move: 1'b1, en_passant: 1'b1, capture: 1'b1,
		default: 1'b0};

	localparam square_t KING_HOME = '{file: 3'd4, rank: 3'd0};     // e1
	localparam square_t KING_SIDE_TO = '{file: 3'd6, rank: 3'd0};  // g1
	localparam square_t QUEEN_SIDE_TO = '{file: 3'd2, rank: 3'd0}; // c1
	localparam logic [2:0] EP_SRC_RANK = 3'd4; // rank 5
	localparam logic [2:0] EP_DST_RANK = 3'd5; // rank 6

endpackage

// ==== position_latch.sv ====
`timescale 1ns/10ps

module position_latch import move_gen_pkg::*; (
	input  logic           clk,
	input  logic           reset,
	input  logic           start,
	input  logic           accept,
	input  board_t         board,
	input  castle_rights_t rights,
	input  logic [7:0]     enp_flags, // bit 0 = file a
	output position_t      position,
	output logic           captured
);

	logic [7:0] pawn_r5;
	logic       king_path_ok;
	logic       queen_path_ok;
	logic       take;

	assign take = start & accept;

	always_comb begin
		for (int f = 0; f < 8; f++) begin
			pawn_r5[f] = (board[32 + f] == WHITE_PAWN); // rank 5 starts at square 32
		end
	end

	// king on e1, f1 g1 empty of any colour, rook on h1
	assign king_path_ok = (board[4] == WHITE_KING) &&
		(board[5].piece == EMPTY) &&
		(board[6].piece == EMPTY) &&
		(board[7] == WHITE_ROOK);

	// b1 c1 d1 empty, rook on a1
	assign queen_path_ok = (board[4] == WHITE_KING) &&
		(board[1].piece == EMPTY) &&
		(board[2].piece == EMPTY) &&
		(board[3].piece == EMPTY) &&
		(board[0] == WHITE_ROOK);

	always_ff @(posedge clk) begin
		if (reset) begin
			captured <= 1'b0;
		end else begin
			captured <= take; // one cycle pulse per accepted start
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			position.white_pawn_r5 <= pawn_r5;
			position.enp           <= enp_flags;
			position.king_side_ok  <= rights.king_side & king_path_ok;
			position.queen_side_ok <= rights.queen_side & queen_path_ok;
		end
	end

endmodule

// ==== special_move_gen.sv ====
`timescale 1ns/10ps

module special_move_gen import move_gen_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      captured,
	input  position_t position,
	input  logic      has_room,
	input  logic      queue_empty,
	output logic      accept,
	output logic      busy,
	output logic      done,
	output logic      wr,
	output move_t     wr_move
);

	gen_state_t              state;
	logic [SLOT_COUNT-1:0]   pending;    // slots still to be written
	logic [SLOT_COUNT-1:0]   cand_valid;
	logic [7:0]              ep_left;
	logic [7:0]              ep_right;
	logic [SLOT_IDX_W-1:0]   sel;
	move_t                   slot_move [SLOT_COUNT];

	// source pawn sits on the neighbouring file, rank 5
	assign ep_left  = position.enp & {position.white_pawn_r5[6:0], 1'b0};
	assign ep_right = position.enp & {1'b0, position.white_pawn_r5[7:1]};

	assign cand_valid[0] = position.king_side_ok;
	assign cand_valid[1] = position.queen_side_ok;
	assign slot_move[0] = '{flags: CASTLE_FLAGS, from_sq: KING_HOME, to_sq: KING_SIDE_TO};
	assign slot_move[1] = '{flags: CASTLE_FLAGS, from_sq: KING_HOME, to_sq: QUEEN_SIDE_TO};

	// slot 2+2f takes from file f-1, slot 3+2f from file f+1
	for (genvar f = 0; f < 8; f++) begin : g_file
		assign cand_valid[2 + 2*f] = ep_left[f];
		assign cand_valid[3 + 2*f] = ep_right[f];
		assign slot_move[2 + 2*f] = '{
			flags:   ENP_FLAGS,
			from_sq: '{file: 3'(f - 1), rank: EP_SRC_RANK},
			to_sq:   '{file: 3'(f), rank: EP_DST_RANK}
		};
		assign slot_move[3 + 2*f] = '{
			flags:   ENP_FLAGS,
			from_sq: '{file: 3'(f + 1), rank: EP_SRC_RANK},
			to_sq:   '{file: 3'(f), rank: EP_DST_RANK}
		};
	end

	// lowest pending slot wins
	always_comb begin
		sel = '0;
		for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
			if (pending[i]) begin
				sel = SLOT_IDX_W'(i);
			end
		end
	end

	// the capture cycle already counts as busy
	assign accept = ((state == IDLE) || (state == DONE)) && !captured;
	assign busy = !accept;
	assign done = (state == DONE) && !captured;

	assign wr = (state == SCAN) && has_room && (|pending);
	assign wr_move = slot_move[sel];

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= IDLE;
			pending <= '0;
		end else begin
			case (state)
				IDLE, DONE: begin
					if (captured) begin
						state <= LOAD;
					end
				end
				LOAD: begin
					pending <= cand_valid;
					state   <= SCAN;
				end
				SCAN: begin
					if (wr) begin
						pending[sel] <= 1'b0;
					end
					if (!(|pending)) begin
						state <= DRAIN;
					end
				end
				DRAIN: begin
					if (queue_empty) begin
						state <= DONE; // last move is on the port this cycle
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

// ==== move_queue.sv ====
`timescale 1ns/10ps

module move_queue import move_gen_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  wr,
	input  move_t wr_move,
	output logic  has_room,
	output logic  queue_empty,
	input  logic  move_credit,
	output logic  move_valid,
	output move_t move_out
);

	move_t                  mem [QUEUE_DEPTH];
	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [QUEUE_PTR_W:0]   count;
	logic [CREDIT_W-1:0]    credits;
	logic                   pop;

	assign has_room    = (count != (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
	assign queue_empty = (count == '0);
	assign pop         = !queue_empty && (credits != '0); // one move per credit

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_ptr] <= wr_move;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr) begin
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, pointers wrap
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// send and return in the same cycle cancel out
	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= CREDIT_W'(QUEUE_CREDITS);
		end else begin
			case ({pop, move_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			move_valid <= 1'b0;
		end else begin
			move_valid <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			move_out <= mem[rd_ptr];
		end
	end

endmodule

// ==== move_gen_top.sv ====
`timescale 1ns/10ps

module move_gen_top import move_gen_pkg::*; (
	input  logic           clk,
	input  logic           reset,
	input  logic           start,
	input  board_t         board,
	input  castle_rights_t rights,
	input  logic [7:0]     enp_flags,
	input  logic           move_credit,
	output logic           busy,
	output logic           done,
	output logic           move_valid,
	output move_t          move_out
);

	position_t position;
	logic      captured;
	logic      accept;
	logic      wr;
	move_t     wr_move;
	logic      has_room;
	logic      queue_empty;

	position_latch latch0 (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.accept    (accept),
		.board     (board),
		.rights    (rights),
		.enp_flags (enp_flags),
		.position  (position),
		.captured  (captured)
	);

	special_move_gen gen0 (
		.clk         (clk),
		.reset       (reset),
		.captured    (captured),
		.position    (position),
		.has_room    (has_room),
		.queue_empty (queue_empty),
		.accept      (accept),
		.busy        (busy),
		.done        (done),
		.wr          (wr),
		.wr_move     (wr_move)
	);

	move_queue queue0 (
		.clk         (clk),
		.reset       (reset),
		.wr          (wr),
		.wr_move     (wr_move),
		.has_room    (has_room),
		.queue_empty (queue_empty),
		.move_credit (move_credit),
		.move_valid  (move_valid),
		.move_out    (move_out)
	);

endmodule

// ==== move_checker.sv ====
`timescale 1ns/10ps

module move_checker import move_gen_pkg::*; (
	input logic  clk,
	input logic  reset,
	input logic  busy,
	input logic  done,
	input logic  move_valid,
	input logic  move_credit,
	input move_t move_out
);

	move_t exp_q [$];
	move_t exp_move;
	string test_name = "";
	int    test_errors = 0;
	int    test_moves = 0;
	int    credits = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    error_count = 0;
	logic  done_q = 1'b0;

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
		test_moves = 0;
		exp_q.delete();
	endtask

	task automatic expect_move(input move_t m);
		exp_q.push_back(m);
	endtask

	task automatic flag_error();
		test_errors++;
		error_count++;
	endtask

	// outputs right after reset
	task automatic check_idle();
		if (busy !== 1'b0) begin
			$display("Mismatch busy: got %h expected 0", busy);
			flag_error();
		end
		if (done !== 1'b0) begin
			$display("Mismatch done: got %h expected 0", done);
			flag_error();
		end
		if (move_valid !== 1'b0) begin
			$display("Mismatch move_valid: got %h expected 0", move_valid);
			flag_error();
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			credits = QUEUE_CREDITS;
			done_q = 1'b0;
		end else begin
			if (move_valid === 1'b1) begin
				test_moves++;
				if (busy !== 1'b1) begin // a run in progress is busy
					$display("Mismatch busy: got %h expected 1", busy);
					flag_error();
				end
				if (credits <= 0) begin
					$display("a move was sent with no credit left in %s", test_name);
					flag_error();
				end
				credits--;
				if (exp_q.size() == 0) begin
					$display("surplus move %h in %s", move_out, test_name);
					flag_error();
				end else begin
					exp_move = exp_q.pop_front();
					if (move_out !== exp_move) begin
						$display("Mismatch move_out: got %h expected %h", move_out, exp_move);
						flag_error();
					end
				end
			end
			if (move_credit === 1'b1) begin
				credits++;
			end
			if (done === 1'b1 && !done_q) begin
				if (busy !== 1'b0) begin
					$display("Mismatch busy: got %h expected 0", busy);
					flag_error();
				end
				if (exp_q.size() != 0) begin
					$display("%0d expected moves never came in %s", exp_q.size(), test_name);
					flag_error();
				end
				tests_run++;
				if (test_errors != 0) begin
					tests_failed++;
				end
				$display("test %0d %s: %s, %0d moves", tests_run, test_name,
					(test_errors == 0) ? "ok" : "failed", test_moves);
			end
			done_q = (done === 1'b1);
		end
	end

endmodule

// ==== tb_move_gen.sv ====
`timescale 1ns/10ps

module tb_move_gen import move_gen_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int NUM_TESTS = 48; // 1 + 4 + 1 + 40 + 1 + 1
	localparam int MAX_TEST_CYCLES = 200;

	logic           clk;
	logic           reset;
	logic           start;
	logic           move_credit;
	logic           busy;
	logic           done;
	logic           move_valid;
	board_t         board;
	castle_rights_t rights;
	logic [7:0]     enp_flags;
	move_t          move_out;
	move_t          exp_list [SLOT_COUNT];
	logic [31:0]    rng = 32'd17426;
	logic           hold_credits = 1'b0;
	logic           credit_ok;
	int             owed = 0; // credits the consumer still has to hand back
	int             tests_started = 0;
	int             t;
	int             f;

	move_gen_top dut0 (
		.clk(clk), .reset(reset), .start(start),
		.board(board), .rights(rights), .enp_flags(enp_flags),
		.move_credit(move_credit), .busy(busy), .done(done),
		.move_valid(move_valid), .move_out(move_out)
	);

	move_checker check0 (
		.clk(clk), .reset(reset), .busy(busy), .done(done),
		.move_valid(move_valid), .move_credit(move_credit), .move_out(move_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(NUM_TESTS * MAX_TEST_CYCLES * CLK_PERIOD);
		$display("timeout, the tests did not finish in time");
		$display("=== FAIL ===");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic move_t make_move(input logic [6:0] flags, input int ff, input int fr,
		input int tf, input int tr);
		return {flags, 3'(ff), 3'(fr), 3'(tf), 3'(tr)}; // flags, from file/rank, to file/rank
	endfunction

	// reference model of the special moves, in emission order
	function automatic int expected_moves();
		int n;
		int i;
		n = 0;
		if (rights.king_side && board[4] == WHITE_KING && board[5].piece == EMPTY &&
			board[6].piece == EMPTY && board[7] == WHITE_ROOK) begin
			exp_list[n] = make_move(7'b0000010, 4, 0, 6, 0);
			n++;
		end
		if (rights.queen_side && board[4] == WHITE_KING && board[1].piece == EMPTY &&
			board[2].piece == EMPTY && board[3].piece == EMPTY && board[0] == WHITE_ROOK) begin
			exp_list[n] = make_move(7'b0000010, 4, 0, 2, 0);
			n++;
		end
		for (i = 0; i < 8; i++) begin
			if (enp_flags[i] && i > 0 && board[31 + i] == WHITE_PAWN) begin
				exp_list[n] = make_move(7'b0010101, i - 1, 4, i, 5); // from the left
				n++;
			end
			if (enp_flags[i] && i < 7 && board[33 + i] == WHITE_PAWN) begin
				exp_list[n] = make_move(7'b0010101, i + 1, 4, i, 5);
				n++;
			end
		end
		return n;
	endfunction

	task automatic load_expected(input string name);
		int n;
		int i;
		n = expected_moves();
		check0.begin_test(name);
		for (i = 0; i < n; i++) begin
			check0.expect_move(exp_list[i]);
		end
		tests_started++;
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(posedge clk);
		#2 start = 1'b0;
	endtask

	task automatic wait_test_end();
		wait (check0.tests_run == tests_started);
		repeat (3) @(posedge clk); // outstanding credits come back
		#2;
	endtask

	task automatic run_test(input string name);
		load_expected(name);
		pulse_start();
		wait_test_end();
	endtask

	task automatic base_position();
		board = '0;
		board[0] = WHITE_ROOK;
		board[4] = WHITE_KING;
		board[7] = WHITE_ROOK;
		rights = '0;
		enp_flags = '0;
	endtask

	// biased so that castling and en passant come up often
	task automatic random_position();
		int sq;
		int k;
		for (sq = 0; sq < 64; sq++) begin
			rng = xorshift(rng);
			board[sq] = rng[3:0];
		end
		rng = xorshift(rng);
		board[4] = (rng[1:0] != 2'b00) ? WHITE_KING : board[4];
		board[0] = (rng[3:2] != 2'b00) ? WHITE_ROOK : board[0];
		board[7] = (rng[5:4] != 2'b00) ? WHITE_ROOK : board[7];
		for (k = 0; k < 5; k++) begin
			sq = (k < 3) ? k + 1 : k + 2; // b1 c1 d1 f1 g1
			board[sq] = (rng[6 + 2*k +: 2] != 2'b00) ? cell_t'(4'h0) : board[sq];
		end
		for (k = 0; k < 8; k++) begin
			board[32 + k] = rng[16 + k] ? WHITE_PAWN : board[32 + k];
		end
		rights = rng[25:24];
		enp_flags = rng[31] ? 8'h00 : 8'h01 << rng[30:28]; // at most one flag
	endtask

	always @(posedge clk) begin
		credit_ok = !hold_credits;
		if (move_valid === 1'b1) begin
			owed++;
		end
		#2;
		if (credit_ok && owed > 0) begin
			move_credit = 1'b1;
			owed--;
		end else begin
			move_credit = 1'b0;
		end
	end

	initial begin
		reset = 1'b1;
		start = 1'b0;
		move_credit = 1'b0;
		base_position();
		repeat (2) @(posedge clk);
		#2 reset = 1'b0;

		load_expected("no rights no flags");
		check0.check_idle();
		pulse_start();
		wait_test_end();

		rights = 2'b11;
		run_test("both castles");
		board[5] = WHITE_ROOK; // f1 taken
		run_test("king side path blocked");
		base_position();
		rights.king_side = 1'b1;
		run_test("queen side right clear");
		rights = 2'b11;
		board[1] = {1'b1, KNIGHT}; // black knight on b1
		run_test("queen side path blocked");

		base_position();
		enp_flags = 8'b1000_1001;
		board[33] = WHITE_PAWN;
		board[34] = WHITE_PAWN;
		board[36] = WHITE_PAWN;
		board[38] = WHITE_PAWN;
		run_test("en passant on a d h");

		for (t = 0; t < 40; t++) begin
			random_position();
			run_test($sformatf("random position %0d", t));
		end

		// 16 moves, more than queue and credits together
		base_position();
		rights = 2'b11;
		enp_flags = 8'hff;
		for (f = 0; f < 8; f++) begin
			board[32 + f] = WHITE_PAWN;
		end
		hold_credits = 1'b1;
		load_expected("credits withheld");
		pulse_start();
		repeat (40) @(posedge clk);
		#2 hold_credits = 1'b0;
		wait_test_end();

		base_position();
		rights = 2'b11;
		load_expected("second start while busy");
		pulse_start();
		rights = 2'b00;
		enp_flags = 8'h08;
		board[36] = WHITE_PAWN;
		pulse_start();
		wait_test_end();

		$display("tests run %0d of %0d, failed %0d, errors %0d", check0.tests_run, NUM_TESTS,
			check0.tests_failed, check0.error_count);
		if (check0.error_count == 0 && check0.tests_run == NUM_TESTS) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== build.f ====
move_gen_pkg.sv
position_latch.sv
special_move_gen.sv
move_queue.sv
move_gen_top.sv
move_checker.sv
tb_move_gen.sv
